// ==== include/sparc_consts.svh ====
`ifndef SPARC_CONSTS_SVH
`define SPARC_CONSTS_SVH

// Datapath and register file geometry
`define WORD_W          32
`define REG_ADDR_W      5
`define NUM_REGS        32
`define CALL_LINK_REG   5'd15    // o7, receives PC of the call

// nPC starts one word ahead of PC
`define NPC_RESET       32'd4

// Major opcode, instr[31:30]
`define OP_BRANCH       2'b00    // Also SETHI and nop
`define OP_CALL         2'b01
`define OP_ARITH        2'b10
`define OP_MEM          2'b11

`define OP3_JMPL        6'b111000
`define OP3_SETHI_OP2   3'b100

// ALU operation codes driven onto the control word
`define ALU_ADD         4'd0
`define ALU_ADDX        4'd1
`define ALU_SUB         4'd2
`define ALU_SUBX        4'd3
`define ALU_AND         4'd4
`define ALU_OR          4'd5
`define ALU_XOR         4'd6
`define ALU_XNOR        4'd7
`define ALU_ANDN        4'd8
`define ALU_ORN         4'd9
`define ALU_SLL         4'd10
`define ALU_SRL         4'd11
`define ALU_SRA         4'd12
`define ALU_PASS_B      4'd14    // SETHI result is just operand B

// Data memory access size
`define SIZE_BYTE       2'b00
`define SIZE_HALF       2'b01
`define SIZE_WORD       2'b10

`endif

// ==== rtl/sparcPkg.sv ====
`include "sparc_consts.svh"

package sparcPkg;

    typedef logic [`WORD_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] regAddr_t;

    // Format 1/2 view, call and branch/SETHI
    typedef struct packed {
        logic [1:0]  op;
        logic        a;          // Annul
        logic [3:0]  cond;
        logic [2:0]  op2;
        logic [21:0] disp22;     // Low part of disp30 for a call
    } brFmt_t;

    // Format 3 view, arithmetic and memory
    typedef struct packed {
        logic [1:0]  op;
        regAddr_t    rd;
        logic [5:0]  op3;
        regAddr_t    rs1;
        logic        i;
        logic [12:0] low13;      // simm13, or rs2 in the low five bits
    } f3Fmt_t;

    typedef union packed {
        brFmt_t br;
        f3Fmt_t f3;
    } instrWord_t;

    typedef struct packed {
        logic       jmpl;
        logic       write;       // 1 means store
        logic [3:0] aluOp;
        logic       signExt;
        logic       load;
        logic       rfEnable;
        logic [1:0] size;
        logic       modifyCc;
        logic       call;
        logic       memEnable;
        logic       branch;
        logic       annul;
    } ctrlWord_t;

    typedef struct packed {
        ctrlWord_t ctrl;
        regAddr_t  rd;
    } decoded_t;

    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } icc_t;

    typedef struct packed {
        logic modifyCc;
        icc_t flags;
    } ccUpdate_t;

    typedef struct packed {
        logic     en;
        regAddr_t addr;
        word_t    data;
    } rfWrite_t;

    typedef struct packed {
        word_t pa;
        word_t pb;
        word_t pd;               // Store data from rd
    } operands_t;

endpackage

// ==== rtl/instrDecoder.sv ====
`include "sparc_consts.svh"

module instrDecoder import sparcPkg::*;
(
    input  instrWord_t instr,
    input  logic       instrValid,
    input  logic       squash,
    output decoded_t   decoded
);

    ctrlWord_t ctrl;
    regAddr_t  rd;

    // op3[3:0] picks the operation, op3[5] moves 5/6/7 over to the shifts
    function automatic logic [3:0] aluCode(input logic [5:0] op3);
        logic [3:0] code;
        case (op3[3:0])
            4'd0:    code = `ALU_ADD;
            4'd8:    code = `ALU_ADDX;
            4'd4:    code = `ALU_SUB;
            4'd12:   code = `ALU_SUBX;
            4'd1:    code = `ALU_AND;
            4'd2:    code = `ALU_OR;
            4'd3:    code = `ALU_XOR;
            4'd5:    code = op3[5] ? `ALU_SLL : `ALU_ANDN;
            4'd6:    code = op3[5] ? `ALU_SRL : `ALU_ORN;
            4'd7:    code = op3[5] ? `ALU_SRA : `ALU_XNOR;
            default: code = `ALU_ADD;
        endcase
        return code;
    endfunction

    always_comb
    begin
        ctrl = '0;
        rd   = instr.f3.rd;

        case (instr.f3.op)
            `OP_CALL:
            begin
                ctrl.call     = 1'b1;
                ctrl.rfEnable = 1'b1;               // Link PC into o7
                rd            = `CALL_LINK_REG;
            end

            `OP_BRANCH:
            begin
                if (instr == '0)
                begin
                    ctrl = '0;                      // Nop word
                end
                else if (instr.br.op2 == `OP3_SETHI_OP2)
                begin
                    ctrl.aluOp    = `ALU_PASS_B;
                    ctrl.rfEnable = 1'b1;
                end
                else
                begin
                    ctrl.branch = 1'b1;
                    ctrl.annul  = instr.br.a;
                end
            end

            `OP_ARITH:
            begin
                ctrl.rfEnable = 1'b1;
                if (instr.f3.op3 == `OP3_JMPL)
                begin
                    ctrl.jmpl  = 1'b1;
                    ctrl.aluOp = `ALU_ADD;          // Target is rs1 + operand
                end
                else
                begin
                    ctrl.aluOp    = aluCode(instr.f3.op3);
                    ctrl.modifyCc = instr.f3.op3[4]; // The cc variants
                end
            end

            `OP_MEM:
            begin
                ctrl.memEnable = 1'b1;
                ctrl.aluOp     = `ALU_ADD;          // Effective address
                ctrl.write     = instr.f3.op3[2];
                ctrl.load      = ~instr.f3.op3[2];
                ctrl.rfEnable  = ~instr.f3.op3[2];
                ctrl.signExt   = instr.f3.op3[3];   // ldsb, ldsh
                case (instr.f3.op3[1:0])
                    2'b01:   ctrl.size = `SIZE_BYTE;
                    2'b10:   ctrl.size = `SIZE_HALF;
                    default: ctrl.size = `SIZE_WORD;
                endcase
            end

            default:
            begin
                ctrl = '0;
            end
        endcase

        // Annulled delay slot or empty cycle
        if (!instrValid || squash)
        begin
            ctrl = '0;
        end

        decoded.ctrl = ctrl;
        decoded.rd   = rd;
    end

endmodule

// ==== rtl/regFile.sv ====
`include "sparc_consts.svh"

module regFile import sparcPkg::*;
(
    input  logic      Clk,
    input  logic      rstN,
    input  rfWrite_t  rfWrite,
    input  regAddr_t  rs1,
    input  regAddr_t  rs2,
    input  regAddr_t  rd,
    output operands_t operands
);

    // r0 has no storage
    word_t regs [1:`NUM_REGS-1];

    function automatic word_t readPort(input regAddr_t addr);
        word_t value;
        value = (addr == '0) ? '0 : regs[addr];
        return value;
    endfunction

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            for (int i = 1; i < `NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (rfWrite.en && (rfWrite.addr != '0))
        begin
            regs[rfWrite.addr] <= rfWrite.data;  // Writes to r0 are dropped
        end
    end

    // No bypass of the write port, new data shows next cycle
    always_comb
    begin
        operands.pa = readPort(rs1);
        operands.pb = readPort(rs2);
        operands.pd = readPort(rd);
    end

endmodule

// ==== rtl/condCodeUnit.sv ====
module condCodeUnit import sparcPkg::*;
(
    input  logic      Clk,
    input  logic      rstN,
    input  ccUpdate_t ccUpdate,
    input  logic [3:0] cond,
    input  logic      branch,
    output logic      taken,
    output icc_t      icc
);

    icc_t ccEff;
    logic baseCond;

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            icc <= '0;
        end
        else if (ccUpdate.modifyCc)
        begin
            icc <= ccUpdate.flags;
        end
    end

    // Flags arriving this cycle win over the stored ones
    assign ccEff = ccUpdate.modifyCc ? ccUpdate.flags : icc;

    // The low three bits pick a test; cond[3] inverts it.
    // That pairs bn/ba, be/bne, ble/bg and so on.
    always_comb
    begin
        case (cond[2:0])
            3'b000:  baseCond = 1'b0;                                   // bn
            3'b001:  baseCond = ccEff.z;                                // be
            3'b010:  baseCond = ccEff.z | (ccEff.n ^ ccEff.v);          // ble
            3'b011:  baseCond = ccEff.n ^ ccEff.v;                      // bl
            3'b100:  baseCond = ccEff.c | ccEff.z;                      // bleu
            3'b101:  baseCond = ccEff.c;                                // bcs
            3'b110:  baseCond = ccEff.n;                                // bneg
            default: baseCond = ccEff.v;                                // bvs
        endcase
    end

    assign taken = branch & (baseCond ^ cond[3]);

endmodule

// ==== rtl/pcSequencer.sv ====
`include "sparc_consts.svh"

module pcSequencer import sparcPkg::*;
(
    input  logic       Clk,
    input  logic       rstN,
    input  logic       instrValid,
    input  instrWord_t instr,
    input  decoded_t   decoded,
    input  logic       taken,
    input  word_t      jmplTarget,
    output word_t      pc,
    output word_t      npc,
    output logic       squash
);

    word_t disp22Ext;
    word_t offset;
    word_t target;
    word_t nextNpc;

    assign disp22Ext = {{(`WORD_W-22){instr.br.disp22[21]}}, instr.br.disp22};

    // disp30 is everything below op; word displacement to byte offset
    assign offset = decoded.ctrl.call ? {instr[29:0], 2'b00}
                                      : {disp22Ext[`WORD_W-3:0], 2'b00};
    assign target = pc + offset;

    always_comb
    begin
        if (decoded.ctrl.jmpl)
        begin
            nextNpc = jmplTarget;
        end
        else if (decoded.ctrl.call || (decoded.ctrl.branch && taken))
        begin
            nextNpc = target;
        end
        else
        begin
            nextNpc = npc + 32'd4;
        end
    end

    // Delayed branch, the slot at old nPC always issues
    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            pc     <= '0;
            npc    <= `NPC_RESET;
            squash <= 1'b0;
        end
        else if (instrValid)
        begin
            pc     <= npc;
            npc    <= nextNpc;
            squash <= decoded.ctrl.annul;   // Kill the delay slot
        end
    end

endmodule

// ==== rtl/sparcDecodeStage.sv ====
module sparcDecodeStage import sparcPkg::*;
(
    input  logic       Clk,
    input  logic       rstN,
    input  instrWord_t instr,
    input  logic       instrValid,
    input  ccUpdate_t  ccUpdate,
    input  rfWrite_t   rfWrite,
    input  word_t      jmplTarget,
    output decoded_t   decoded,
    output operands_t  operands,
    output icc_t       icc,
    output logic       taken,
    output word_t      pc,
    output word_t      npc
);

    logic squash;

    instrDecoder uDecoder (
        .instr      (instr),
        .instrValid (instrValid),
        .squash     (squash),
        .decoded    (decoded)
    );

    // Store data comes from rd, rs2 from the low bits of simm13
    regFile uRegFile (
        .Clk      (Clk),
        .rstN     (rstN),
        .rfWrite  (rfWrite),
        .rs1      (instr.f3.rs1),
        .rs2      (instr.f3.low13[4:0]),
        .rd       (instr.f3.rd),
        .operands (operands)
    );

    condCodeUnit uCondCode (
        .Clk      (Clk),
        .rstN     (rstN),
        .ccUpdate (ccUpdate),
        .cond     (instr.br.cond),
        .branch   (decoded.ctrl.branch),
        .taken    (taken),
        .icc      (icc)
    );

    pcSequencer uPcSeq (
        .Clk        (Clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .decoded    (decoded),
        .taken      (taken),
        .jmplTarget (jmplTarget),
        .pc         (pc),
        .npc        (npc),
        .squash     (squash)
    );

endmodule

// ==== verif/tbSparcDecodeStage.sv ====
module tbSparcDecodeStage import sparcPkg::*;
();

    localparam int maxLines     = 200;
    localparam int resetTimeout = 20;

    logic       Clk;
    logic       rstN;
    instrWord_t instr;
    logic       instrValid;
    ccUpdate_t  ccUpdate;
    rfWrite_t   rfWrite;
    word_t      jmplTarget;
    decoded_t   decoded;
    operands_t  operands;
    icc_t       icc;
    logic       taken;
    word_t      pc;
    word_t      npc;

    word_t pcModel;             // Expected PC and nPC
    word_t npcModel;
    icc_t  iccModel;            // Expected stored flags
    int    testErrors;
    int    passCount;
    int    failCount;

    sparcDecodeStage DUT (.*);

    initial
    begin
        Clk = 1'b0;
        forever
        begin
            #50 Clk = ~Clk;
        end
    end

    // Low over three rising edges
    initial
    begin
        rstN = 1'b0;
        repeat (3) @(posedge Clk);
        @(negedge Clk);
        rstN = 1'b1;
    end

    task automatic checkDecoded(input decoded_t got, input decoded_t exp);
        if (got !== exp)
        begin
            $display("Error @%0t: decoded ctrl %h rd %0d, expected ctrl %h rd %0d",
                     $time, got.ctrl, got.rd, exp.ctrl, exp.rd);
            testErrors++;
        end
    endtask

    task automatic checkOperands(input operands_t got, input operands_t exp);
        if (got !== exp)
        begin
            $display("Error @%0t: operands %h %h %h, expected %h %h %h", $time,
                     got.pa, got.pb, got.pd, exp.pa, exp.pb, exp.pd);
            testErrors++;
        end
    endtask

    task automatic checkTaken(input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Error @%0t: taken %b, expected %b", $time, got, exp);
            testErrors++;
        end
    endtask

    task automatic checkIcc(input icc_t got, input icc_t exp);
        if (got !== exp)
        begin
            $display("Error @%0t: icc %b, expected %b", $time, got, exp);
            testErrors++;
        end
    endtask

    task automatic checkPc(input word_t got, input word_t exp, input string name);
        if (got !== exp)
        begin
            $display("Error @%0t: %s %h, expected %h", $time, name, got, exp);
            testErrors++;
        end
    endtask

    // Drive on the falling edge and sample just before the rising edge
    task automatic runVector(input word_t col [0:14]);
        decoded_t  expDec;
        operands_t expOps;
        logic      expTaken;
        word_t     nextNpc;

        @(negedge Clk);
        instr             = col[1];
        instrValid        = col[2][0];
        ccUpdate.modifyCc = col[3][0];
        ccUpdate.flags    = col[4][3:0];
        rfWrite.en        = col[5][0];
        rfWrite.addr      = col[6][4:0];
        rfWrite.data      = col[7];
        jmplTarget        = col[8];
        expDec.ctrl       = col[9][15:0];
        expDec.rd         = col[10][4:0];
        expOps.pa         = col[11];
        expOps.pb         = col[12];
        expOps.pd         = col[13];
        expTaken          = col[14][0];

        #40;                                    // Rising edge still ahead
        testErrors = 0;
        checkDecoded(decoded, expDec);
        checkOperands(operands, expOps);
        checkTaken(taken, expTaken);
        checkIcc(icc, iccModel);
        checkPc(pc, pcModel, "pc");
        checkPc(npc, npcModel, "npc");

        // Model PC and nPC in delayed-branch order
        if (instrValid)
        begin
            nextNpc = expDec.ctrl.jmpl ? jmplTarget
                    : expDec.ctrl.call ? pcModel + {instr[29:0], 2'b00}
                    : (expDec.ctrl.branch && expTaken)
                        ? pcModel + {{8{instr[21]}}, instr[21:0], 2'b00}
                    : npcModel + 32'd4;
            pcModel  = npcModel;
            npcModel = nextNpc;
        end

        // New flags are stored at the coming edge
        if (ccUpdate.modifyCc)
        begin
            iccModel = ccUpdate.flags;
        end

        if (testErrors == 0)
        begin
            passCount++;
        end
        else
        begin
            failCount++;
        end
        $display("Test %0d kind %0h %s", passCount + failCount, col[0],
                 (testErrors == 0) ? "passed" : "failed");
    endtask

    initial
    begin
        int    fd;
        int    lineNo;
        int    nFields;
        int    waitCycles;
        string line;
        word_t col [0:14];

        instr      = '0;
        instrValid = 1'b0;
        ccUpdate   = '0;
        rfWrite    = '0;
        jmplTarget = '0;
        pcModel    = '0;
        npcModel   = 32'd4;             // nPC after reset
        iccModel   = '0;
        passCount  = 0;
        failCount  = 0;

        waitCycles = 0;
        while (rstN !== 1'b1 && waitCycles < resetTimeout)
        begin
            @(negedge Clk);
            waitCycles++;
        end
        if (rstN !== 1'b1)
        begin
            $display("Timeout: reset was not released within %0d cycles", resetTimeout);
            $display("CHECKS FAILED");
            $finish;
        end

        fd = $fopen("verif/decode_input.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the vector file verif/decode_input.txt");
            $display("CHECKS FAILED");
            $finish;
        end

        lineNo = 0;
        while (!$feof(fd) && lineNo < maxLines)
        begin
            lineNo++;
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#")
            begin
                continue;                       // Blank or column notes
            end
            nFields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                              col[7], col[8], col[9], col[10], col[11], col[12],
                              col[13], col[14]);
            if (nFields != 15)
            begin
                $display("Vector on line %0d has %0d fields instead of 15", lineNo, nFields);
                failCount++;
            end
            else
            begin
                runVector(col);
            end
        end
        $fclose(fd);

        $display("Tests run %0d, passed %0d, failed %0d",
                 passCount + failCount, passCount, failCount);
        if (failCount == 0 && passCount > 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/decode_input.txt ====
# kind instr valid ccMod ccFlags(NZVC) rfEn rfAddr rfData jmplTarget expCtrl expRd expPa expPb expPd expTaken
# All hex. Kind 1 alu, 2 mem, 3 regfile, 4 branch, 5 call/jmpl/annul
1 82808003 1 0 0 0 00 00000000 00000000 0090 01 00000000 00000000 00000000 0
1 82408003 1 0 0 0 00 00000000 00000000 0480 01 00000000 00000000 00000000 0
1 82208003 1 0 0 0 00 00000000 00000000 0880 01 00000000 00000000 00000000 0
1 82608003 1 0 0 0 00 00000000 00000000 0C80 01 00000000 00000000 00000000 0
1 82888003 1 0 0 0 00 00000000 00000000 1090 01 00000000 00000000 00000000 0
1 82108003 1 0 0 0 00 00000000 00000000 1480 01 00000000 00000000 00000000 0
1 82188003 1 0 0 0 00 00000000 00000000 1880 01 00000000 00000000 00000000 0
1 82288003 1 0 0 0 00 00000000 00000000 2080 01 00000000 00000000 00000000 0
1 82308003 1 0 0 0 00 00000000 00000000 2480 01 00000000 00000000 00000000 0
1 82388003 1 0 0 0 00 00000000 00000000 1C80 01 00000000 00000000 00000000 0
1 83288003 1 0 0 0 00 00000000 00000000 2880 01 00000000 00000000 00000000 0
1 83308003 1 0 0 0 00 00000000 00000000 2C80 01 00000000 00000000 00000000 0
1 83388003 1 0 0 0 00 00000000 00000000 3080 01 00000000 00000000 00000000 0
1 09012345 1 0 0 0 00 00000000 00000000 3880 04 00000000 00000000 00000000 0
1 00000000 1 0 0 0 00 00000000 00000000 0000 00 00000000 00000000 00000000 0
2 CA00A008 1 0 0 0 00 00000000 00000000 01C4 05 00000000 00000000 00000000 0
2 CA08A008 1 0 0 0 00 00000000 00000000 0184 05 00000000 00000000 00000000 0
2 CA10A008 1 0 0 0 00 00000000 00000000 01A4 05 00000000 00000000 00000000 0
2 CA48A008 1 0 0 0 00 00000000 00000000 0384 05 00000000 00000000 00000000 0
2 CA50A008 1 0 0 0 00 00000000 00000000 03A4 05 00000000 00000000 00000000 0
2 CA20A008 1 0 0 0 00 00000000 00000000 4044 05 00000000 00000000 00000000 0
2 CA28A008 1 0 0 0 00 00000000 00000000 4004 05 00000000 00000000 00000000 0
2 CA30A008 1 1 9 0 00 00000000 00000000 4024 05 00000000 00000000 00000000 0
4 00800010 1 0 0 0 00 00000000 00000000 0002 00 00000000 00000000 00000000 0
4 02BFFFF8 1 0 0 0 00 00000000 00000000 0002 01 00000000 00000000 00000000 0
4 04800010 1 0 0 0 00 00000000 00000000 0002 02 00000000 00000000 00000000 1
4 06BFFFF8 1 0 0 0 00 00000000 00000000 0002 03 00000000 00000000 00000000 1
4 08800010 1 0 0 0 00 00000000 00000000 0002 04 00000000 00000000 00000000 1
4 0ABFFFF8 1 0 0 0 00 00000000 00000000 0002 05 00000000 00000000 00000000 1
4 0C800010 1 0 0 0 00 00000000 00000000 0002 06 00000000 00000000 00000000 1
# bvs sees the flags arriving in its own cycle
4 0EBFFFF8 1 1 A 0 00 00000000 00000000 0002 07 00000000 00000000 00000000 1
4 10800010 1 0 0 0 00 00000000 00000000 0002 08 00000000 00000000 00000000 1
4 12BFFFF8 1 0 0 0 00 00000000 00000000 0002 09 00000000 00000000 00000000 1
4 14800010 1 0 0 0 00 00000000 00000000 0002 0A 00000000 00000000 00000000 1
4 16BFFFF8 1 0 0 0 00 00000000 00000000 0002 0B 00000000 00000000 00000000 1
4 18800010 1 0 0 0 00 00000000 00000000 0002 0C 00000000 00000000 00000000 1
4 1ABFFFF8 1 0 0 0 00 00000000 00000000 0002 0D 00000000 00000000 00000000 1
4 1C800010 1 0 0 0 00 00000000 00000000 0002 0E 00000000 00000000 00000000 0
4 1EBFFFF8 1 0 0 0 00 00000000 00000000 0002 0F 00000000 00000000 00000000 0
5 40000100 1 0 0 0 00 00000000 00000000 0088 0F 00000000 00000000 00000000 0
5 8FC06000 1 0 0 0 00 00000000 00001000 8080 07 00000000 00000000 00000000 0
5 30800010 1 0 0 0 00 00000000 00000000 0003 18 00000000 00000000 00000000 1
5 82008003 0 0 0 0 00 00000000 00000000 0000 01 00000000 00000000 00000000 0
5 82008003 1 0 0 0 00 00000000 00000000 0000 01 00000000 00000000 00000000 0
5 82008003 1 0 0 0 00 00000000 00000000 0080 01 00000000 00000000 00000000 0
3 82008003 1 0 0 1 03 DEADBEEF 00000000 0080 01 00000000 00000000 00000000 0
3 82008003 1 0 0 1 02 12345678 00000000 0080 01 00000000 DEADBEEF 00000000 0
3 82008003 1 0 0 1 01 0000CAFE 00000000 0080 01 12345678 DEADBEEF 00000000 0
3 82008003 1 0 0 1 00 FFFFFFFF 00000000 0080 01 12345678 DEADBEEF 0000CAFE 0
3 80000000 1 0 0 0 00 00000000 00000000 0080 00 00000000 00000000 00000000 0

// ==== src.f ====
+incdir+include
rtl/sparcPkg.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/condCodeUnit.sv
rtl/pcSequencer.sv
rtl/sparcDecodeStage.sv
verif/tbSparcDecodeStage.sv

// ==== run.sh ====
#!/bin/sh
set -e

verilator --binary --timing -f src.f --top-module tbSparcDecodeStage -o simv
./obj_dir/simv | tee sim.log

if grep -q "^ALL CHECKS PASSED$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
